// File: Makefile
# Verilator build and run of the merge node testbench

VERILATOR ?= verilator
TOP       ?= merger_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
verilog/merge_rec_pkg.sv
verilog/merge_ctrl_pkg.sv
verilog/beat_fifo.sv
verilog/merge_control.sv
verilog/block_merger.sv
verilog/record_merger_top.sv
sim/merger_tb.sv

// File: sim/merger_tb.sv
`timescale 1ns/1ps

module merger_tb
   import merge_rec_pkg::*;
();

   localparam int R        = 4;
   localparam int DEPTH    = 8;
   localparam int NUM_RUNS = 8;

   typedef rec_t [R-1:0] beat_t;

   typedef struct packed {
      logic [7:0]  na;
      logic [7:0]  nb;
      logic [15:0] mask;
      logic        toggle;
   } run_cfg_t;

   // Data beats on A and B, key mask, ready toggling
   localparam run_cfg_t RUNS [NUM_RUNS] = '{
      '{8'd3,  8'd3,  16'hffff, 1'b0},
      '{8'd5,  8'd2,  16'hffff, 1'b0},
      '{8'd0,  8'd4,  16'hffff, 1'b0},
      '{8'd3,  8'd0,  16'hffff, 1'b0},
      '{8'd0,  8'd0,  16'hffff, 1'b0},
      '{8'd6,  8'd6,  16'h0007, 1'b0},
      '{8'd32, 8'd32, 16'hffff, 1'b1},
      '{8'd4,  8'd4,  16'h00ff, 1'b0}
   };

   logic  i_clk;
   logic  i_rst_n;
   logic  i_a_push;
   beat_t i_a_beat;
   logic  i_b_push;
   beat_t i_b_beat;
   logic  i_out_ready;
   logic  o_a_full;
   logic  o_b_full;
   logic  o_out_valid;
   beat_t o_out_beat;
   logic  o_out_last;

   logic [31:0] lfsr = 32'hb17ecd66;
   int          hold = 0;
   logic        level = 1'b1;
   int          cycles = 0;
   int          limit = 0;
   logic        full_seen = 1'b0;
   beat_t       a_beats[$];
   beat_t       b_beats[$];
   beat_t       exp_beats[$];
   logic        exp_last[$];
   logic        exp_tog[$];

   record_merger_top #(.RECS_PER_BEAT(R), .FIFO_DEPTH(DEPTH)) dut0 (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_a_push(i_a_push), .i_a_beat(i_a_beat), .i_b_push(i_b_push), .i_b_beat(i_b_beat),
      .i_out_ready(i_out_ready), .o_a_full(o_a_full), .o_b_full(o_b_full),
      .o_out_valid(o_out_valid), .o_out_beat(o_out_beat), .o_out_last(o_out_last)
   );

   // Taps 32, 22, 2, 1
   function automatic logic rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] get_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   function automatic logic [KEY_W-1:0] draw_key(input logic [15:0] mask);
      logic [KEY_W-1:0] k;
      do begin
         k = 16'(get_bits(16)) & mask;
      end while (k == '0 || k == SENTINEL_KEY);
      return k;
   endfunction

   // Zero record stays all zero, all others carry the inverted key as value
   function automatic rec_t rec_of(input logic [KEY_W-1:0] k);
      rec_t r;
      r.key   = k;
      r.value = (k == '0) ? '0 : ~k;
      return r;
   endfunction

   function automatic beat_t make_beat(input logic [KEY_W-1:0] keys[$], input int start);
      beat_t bt;
      for (int j = 0; j < R; j++) begin
         bt[j] = rec_of(keys[start+j]);
      end
      return bt;
   endfunction

   // Long low stretches so the FIFOs fill up
   function automatic logic next_ready();
      if (hold == 0) begin
         level = rand_bit();
         hold  = level ? 1 + int'(get_bits(3)) : 20 + int'(get_bits(4));
      end
      hold--;
      return level;
   endfunction

   task automatic build_run(input int r);
      logic [KEY_W-1:0] ka[$];
      logic [KEY_W-1:0] kb[$];
      logic [KEY_W-1:0] ek[$];
      logic [KEY_W-1:0] all[$];
      logic [KEY_W-1:0] k;
      int               total;
      for (int i = 0; i < int'(RUNS[r].na) * R; i++) begin
         k = draw_key(RUNS[r].mask);
         ka.push_back(k);
         all.push_back(k);
      end
      for (int i = 0; i < int'(RUNS[r].nb) * R; i++) begin
         k = draw_key(RUNS[r].mask);
         kb.push_back(k);
         all.push_back(k);
      end
      ka.sort();
      kb.sort();
      all.sort();
      for (int j = 0; j < R; j++) begin
         ka.push_back(SENTINEL_KEY);
         kb.push_back(SENTINEL_KEY);
         ek.push_back('0);
      end
      foreach (all[i]) ek.push_back(all[i]);
      for (int j = 0; j < R; j++) ek.push_back(SENTINEL_KEY);
      for (int b = 0; b <= int'(RUNS[r].na); b++) a_beats.push_back(make_beat(ka, b * R));
      for (int b = 0; b <= int'(RUNS[r].nb); b++) b_beats.push_back(make_beat(kb, b * R));
      total = int'(RUNS[r].na) + int'(RUNS[r].nb) + 2;
      for (int b = 0; b < total; b++) begin
         exp_beats.push_back(make_beat(ek, b * R));
         exp_last.push_back(b == total - 1);
         exp_tog.push_back(RUNS[r].toggle);
      end
   endtask

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped after an error");
   endtask

   task automatic check_beat(input beat_t got, input beat_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_last(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic push_beats();
      while (a_beats.size() > 0 || b_beats.size() > 0) begin
         @(negedge i_clk);
         i_a_push = (a_beats.size() > 0) && !o_a_full;
         if (i_a_push) i_a_beat = a_beats.pop_front();
         i_b_push = (b_beats.size() > 0) && !o_b_full;
         if (i_b_push) i_b_beat = b_beats.pop_front();
      end
      @(negedge i_clk);
      i_a_push = 1'b0;
      i_b_push = 1'b0;
   endtask

   // A beat seen with valid and ready at the falling edge leaves at the next rising edge
   task automatic collect_beats();
      while (exp_beats.size() > 0) begin
         @(negedge i_clk);
         // Input A backs up while the output of the toggled run stalls
         if (o_a_full && exp_tog.size() > 0 && exp_tog[0]) begin
            full_seen = 1'b1;
         end
         if (o_out_valid && i_out_ready) begin
            check_beat(o_out_beat, exp_beats.pop_front(), "output beat");
            check_last(o_out_last, exp_last.pop_front(), "output last flag");
            void'(exp_tog.pop_front());
         end
         i_out_ready = (exp_tog.size() > 0 && exp_tog[0]) ? next_ready() : 1'b1;
      end
   endtask

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   initial begin
      for (int r = 0; r < NUM_RUNS; r++) begin
         limit += 40 * (int'(RUNS[r].na) + int'(RUNS[r].nb) + 2);
      end
      forever begin
         @(posedge i_clk);
         cycles++;
         if (cycles > limit) begin
            $display("Timeout: the output stream did not finish within %0d cycles", limit);
            abort_run();
         end
      end
   end

   initial begin
      i_rst_n     = 1'b0;
      i_a_push    = 1'b0;
      i_a_beat    = '0;
      i_b_push    = 1'b0;
      i_b_beat    = '0;
      i_out_ready = 1'b0;
      for (int r = 0; r < NUM_RUNS; r++) build_run(r);
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;
      @(negedge i_clk);
      check_last(o_out_valid, 1'b0, "o_out_valid after reset");
      check_last(o_a_full, 1'b0, "o_a_full after reset");
      check_last(o_b_full, 1'b0, "o_b_full after reset");
      fork
         push_beats();
         collect_beats();
      join
      repeat (4) @(negedge i_clk);
      check_last(o_out_valid, 1'b0, "o_out_valid after the last run");
      if (!full_seen) begin
         $display("o_a_full never rose during the back-pressure run");
         abort_run();
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: verilog/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo
   import merge_ctrl_pkg::*;
#(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = FIFO_DEPTH_DEF
) (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_push,
   input  payload_t                   i_data,
   input  logic                       i_pop,
   output payload_t                   o_data,
   output logic                       o_empty,
   output logic                       o_full,
   output logic [$clog2(DEPTH+1)-1:0] o_count
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   payload_t      mem [DEPTH];
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] wr_ptr;
   logic [CW-1:0] count;
   logic          do_push;
   logic          do_pop;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // Pushes into a full FIFO are dropped
   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop;

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CW'(do_push) - CW'(do_pop);
      end
   end

   // Show-ahead head
   assign o_data  = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full  = (count == CW'(DEPTH));
   assign o_count = count;

endmodule

// File: verilog/block_merger.sv
`timescale 1ns/1ps

module block_merger
   import merge_rec_pkg::*;
#(
   parameter int RECS_PER_BEAT = 4
) (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_take,
   input  logic                     i_sel_b,
   input  logic                     i_last,
   input  rec_t [RECS_PER_BEAT-1:0] i_a_beat,
   input  rec_t [RECS_PER_BEAT-1:0] i_b_beat,
   output logic                     o_valid,
   output rec_t [RECS_PER_BEAT-1:0] o_beat,
   output logic                     o_last
);

   localparam int N2     = 2 * RECS_PER_BEAT;
   localparam int LEVELS = $clog2(N2);

   rec_t [RECS_PER_BEAT-1:0] pick;
   rec_t [RECS_PER_BEAT-1:0] kept;
   rec_t [RECS_PER_BEAT-1:0] low_half;
   rec_t [RECS_PER_BEAT-1:0] high_half;
   rec_t                     net [LEVELS+1][N2];

   assign pick = i_sel_b ? i_b_beat : i_a_beat;

   // Retained half ascending, new beat reversed, so the joined sequence is bitonic
   for (genvar gi = 0; gi < RECS_PER_BEAT; gi++) begin : g_load
      assign net[0][gi]               = kept[gi];
      assign net[0][RECS_PER_BEAT+gi] = pick[RECS_PER_BEAT-1-gi];
   end

   // Half-cleaner levels with distance N, N/2, ... 1
   for (genvar lv = 0; lv < LEVELS; lv++) begin : g_level
      localparam int D = RECS_PER_BEAT >> lv;
      for (genvar gi = 0; gi < N2; gi++) begin : g_node
         if ((gi & D) == 0) begin : g_cmp
            logic swap;
            assign swap = (net[lv][gi].key > net[lv][gi+D].key);
            assign net[lv+1][gi]   = swap ? net[lv][gi+D] : net[lv][gi];
            assign net[lv+1][gi+D] = swap ? net[lv][gi] : net[lv][gi+D];
         end
      end
   end

   for (genvar gi = 0; gi < RECS_PER_BEAT; gi++) begin : g_split
      assign low_half[gi]  = net[LEVELS][gi];
      assign high_half[gi] = net[LEVELS][RECS_PER_BEAT+gi];
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid <= 1'b0;
         o_last  <= 1'b0;
         kept    <= '0;
      end else begin
         o_valid <= i_take;
         if (i_take) begin
            o_last <= i_last;
            // High half of the last merge is all sentinels and is dropped
            kept   <= i_last ? '0 : high_half;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_take) begin
         o_beat <= low_half;
      end
   end

endmodule

// File: verilog/merge_control.sv
`timescale 1ns/1ps

module merge_control
   import merge_rec_pkg::*;
   import merge_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
   input  logic                            i_clk,
   input  logic                            i_rst_n,
   input  logic [KEY_W-1:0]                i_a_head_key,
   input  logic                            i_a_empty,
   input  logic [KEY_W-1:0]                i_b_head_key,
   input  logic                            i_b_empty,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] i_out_count,
   output logic                            o_pop_a,
   output logic                            o_pop_b,
   output logic                            o_take,
   output logic                            o_sel_b,
   output logic                            o_last
);

   run_state_t state;
   run_state_t state_nxt;
   logic       a_term;
   logic       b_term;
   logic       out_room;
   logic       want_b;
   logic       go;
   logic       last_take;

   assign a_term = (i_a_head_key == SENTINEL_KEY);
   assign b_term = (i_b_head_key == SENTINEL_KEY);

   // Count the beat still in the merger as well as the new one
   assign out_room = (int'(i_out_count) + 1) < FIFO_DEPTH;

   always_comb begin
      want_b    = 1'b0;
      go        = 1'b0;
      last_take = 1'b0;
      state_nxt = state;
      case (state)
         RUN: begin
            // Smaller first key wins, A on ties, a terminal head loses
            if (a_term) begin
               want_b = ~b_term;
            end else if (!b_term) begin
               want_b = (i_b_head_key < i_a_head_key);
            end
            go = ~i_a_empty & ~i_b_empty & out_room;
            if (go && want_b && b_term) begin
               state_nxt = B_DONE;
            end else if (go && !want_b && a_term) begin
               state_nxt = A_DONE;
            end
         end
         A_DONE: begin
            want_b = 1'b1;
            go     = ~i_b_empty & out_room;
            if (go && b_term) begin
               last_take = 1'b1;
               state_nxt = RUN;
            end
         end
         B_DONE: begin
            go = ~i_a_empty & out_room;
            if (go && a_term) begin
               last_take = 1'b1;
               state_nxt = RUN;
            end
         end
         default: state_nxt = RUN;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= RUN;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_take  = go;
   assign o_sel_b = want_b;
   assign o_pop_a = go & ~want_b;
   assign o_pop_b = go & want_b;
   assign o_last  = last_take;

endmodule

// File: verilog/merge_ctrl_pkg.sv
package merge_ctrl_pkg;

   // Run progress of the merge node
   typedef enum logic [1:0] {
      RUN    = 2'd0,
      A_DONE = 2'd1,
      B_DONE = 2'd2
   } run_state_t;

   // Beats per FIFO unless the top level says otherwise
   localparam int FIFO_DEPTH_DEF = 8;

endpackage

// File: verilog/merge_rec_pkg.sv
package merge_rec_pkg;

   // Record field widths
   localparam int KEY_W = 16;
   localparam int VAL_W = 16;

   // Value sits above the key so the key is the low slice of a record
   typedef struct packed {
      logic [VAL_W-1:0] value;
      logic [KEY_W-1:0] key;
   } rec_t;

   // Terminal beats carry this key in every record, it sorts after all data
   localparam logic [KEY_W-1:0] SENTINEL_KEY = '1;

endpackage

// File: verilog/record_merger_top.sv
`timescale 1ns/1ps

module record_merger_top
   import merge_rec_pkg::*;
   import merge_ctrl_pkg::*;
#(
   parameter int RECS_PER_BEAT = 4,
   parameter int FIFO_DEPTH    = FIFO_DEPTH_DEF
) (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_a_push,
   input  rec_t [RECS_PER_BEAT-1:0] i_a_beat,
   input  logic                     i_b_push,
   input  rec_t [RECS_PER_BEAT-1:0] i_b_beat,
   input  logic                     i_out_ready,
   output logic                     o_a_full,
   output logic                     o_b_full,
   output logic                     o_out_valid,
   output rec_t [RECS_PER_BEAT-1:0] o_out_beat,
   output logic                     o_out_last
);

   typedef rec_t [RECS_PER_BEAT-1:0] beat_t;

   typedef struct packed {
      logic  last;
      beat_t beat;
   } out_beat_t;

   beat_t                           a_head;
   beat_t                           b_head;
   logic                            a_empty;
   logic                            b_empty;
   logic                            pop_a;
   logic                            pop_b;
   logic                            take;
   logic                            sel_b;
   logic                            take_last;
   logic                            m_valid;
   beat_t                           m_beat;
   logic                            m_last;
   out_beat_t                       out_head;
   logic                            out_empty;
   logic [$clog2(FIFO_DEPTH+1)-1:0] out_count;

   beat_fifo #(.payload_t(beat_t), .DEPTH(FIFO_DEPTH)) fifo_a (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(i_a_push), .i_data(i_a_beat),
      .i_pop(pop_a), .o_data(a_head), .o_empty(a_empty), .o_full(o_a_full), .o_count()
   );

   beat_fifo #(.payload_t(beat_t), .DEPTH(FIFO_DEPTH)) fifo_b (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(i_b_push), .i_data(i_b_beat),
      .i_pop(pop_b), .o_data(b_head), .o_empty(b_empty), .o_full(o_b_full), .o_count()
   );

   merge_control #(.FIFO_DEPTH(FIFO_DEPTH)) u_control (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_a_head_key(a_head[0].key), .i_a_empty(a_empty),
      .i_b_head_key(b_head[0].key), .i_b_empty(b_empty),
      .i_out_count(out_count),
      .o_pop_a(pop_a), .o_pop_b(pop_b), .o_take(take), .o_sel_b(sel_b), .o_last(take_last)
   );

   block_merger #(.RECS_PER_BEAT(RECS_PER_BEAT)) u_merger (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_take(take), .i_sel_b(sel_b), .i_last(take_last),
      .i_a_beat(a_head), .i_b_beat(b_head),
      .o_valid(m_valid), .o_beat(m_beat), .o_last(m_last)
   );

   // Output beats carry the last flag above the records
   beat_fifo #(.payload_t(out_beat_t), .DEPTH(FIFO_DEPTH)) fifo_out (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(m_valid), .i_data({m_last, m_beat}),
      .i_pop(o_out_valid & i_out_ready), .o_data(out_head), .o_empty(out_empty),
      .o_full(), .o_count(out_count)
   );

   assign o_out_valid = ~out_empty;
   assign o_out_beat  = out_head.beat;
   assign o_out_last  = out_head.last;

endmodule
